/* design/fe6_mnr_settings.svh */
`ifndef FE6_MNR_SETTINGS_SVH
`define FE6_MNR_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// field parameters for the bls12-381 base field.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// width of one fp element.
`define FE_BITS 381

// base prime p.
`define FE_MODULUS 381'h1a0111ea397fe69a4b1ba7b6434bacd764774b84f38512bf6730d2a0f6b0f6241eabfffeb153ffffb9feffffffffaaab

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stream side-band.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define TAG_BITS 8  // user tag, travels with each item.

`endif

/* design/fe6_mnr_pkg.sv */
`include "fe6_mnr_settings.svh"

package fe6_mnr_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // field element types.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [`FE_BITS-1:0] fe_t;  // one fp element, always kept in [0, p).

  // fp2 = c0 + c1*u, c0 sits in the low bits.
  typedef struct packed {
    fe_t c1;  // u coefficient.
    fe_t c0;  // constant coefficient.
  } fe2_t;

  // fp6 = c0 + c1*v + c2*v^2 over fp2.
  typedef struct packed {
    fe2_t c2;  // v^2 coefficient.
    fe2_t c1;  // v coefficient.
    fe2_t c0;  // constant coefficient.
  } fe6_t;

  typedef logic [`TAG_BITS-1:0] tag_t;  // user tag.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stream beats, valid and ready travel beside these.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // beat on the fp6 ports.
  typedef struct packed {
    tag_t tag;  // follows the item end to end.
    fe6_t dat;  // payload.
  } fe6_beat_t;

  // beat on the internal fp2 request/return channel.
  typedef struct packed {
    tag_t tag;  // copied from the fp6 item.
    fe2_t dat;  // payload.
  } fe2_beat_t;

endpackage

/* design/fp_mod_addsub.sv */
`timescale 1ns/10ps
`include "fe6_mnr_settings.svh"

module fp_mod_addsub
  import fe6_mnr_pkg::*;
#(
  parameter bit SUB = 1'b0  // 0 = add, 1 = subtract.
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_en,   // load a new result.
  input  fe_t  i_a,    // must be < p.
  input  fe_t  i_b,    // must be < p.
  output fe_t  o_res   // a +/- b mod p.
);

  // modulus with one guard bit on top.
  localparam logic [`FE_BITS:0] P_EXT = {1'b0, `FE_MODULUS};

  logic [`FE_BITS:0] raw;  // sum or difference with one extra bit.
  fe_t               red;  // reduced back into [0, p).

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // combinational reduction.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  generate
    if (SUB) begin : g_sub
      always_comb begin
        raw = {1'b0, i_a} - {1'b0, i_b};  // top bit is the borrow.
        if (raw[`FE_BITS]) begin
          red = fe_t'(raw + P_EXT);  // a < b, wrap by adding p.
        end else begin
          red = raw[`FE_BITS-1:0];  // already in range.
        end
      end
    end else begin : g_add
      always_comb begin
        raw = {1'b0, i_a} + {1'b0, i_b};  // at most 2p - 2, fits.
        if (raw >= P_EXT) begin
          red = fe_t'(raw - P_EXT);  // one subtraction is enough.
        end else begin
          red = raw[`FE_BITS-1:0];
        end
      end
    end
  endgenerate

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result register.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_res <= '0;
    end else if (i_en) begin
      o_res <= red;  // holds while the parent stalls.
    end
  end

  // a loaded result stays a canonical field element, which needs the
  // caller to feed reduced operands.
  a_res_reduced : assert property (
    @(posedge i_clk) disable iff (i_rst)
    $past(i_en) |-> (o_res < `FE_MODULUS)
  ) else $error("fp_mod_addsub: result not below p.");

endmodule

/* design/fe2_mul_by_nonresidue.sv */
`timescale 1ns/10ps

module fe2_mul_by_nonresidue
  import fe6_mnr_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  // request channel, (a + b*u).
  input  fe2_beat_t i_req,
  input  logic      i_req_val,
  output logic      o_req_rdy,
  // return channel, (a - b) + (a + b)*u.
  output fe2_beat_t o_ret,
  output logic      o_ret_val,
  input  logic      i_ret_rdy
);

  logic adv;       // return slot empty or draining this cycle.
  logic req_take;  // request transfers on this edge.
  logic ret_val;   // return slot holds a result.
  tag_t ret_tag;   // tag of the held result.
  fe_t  res_c0;    // a - b mod p.
  fe_t  res_c1;    // a + b mod p.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake, one stage deep.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    adv       = ~ret_val | i_ret_rdy;
    o_req_rdy = adv;                // ready follows the output slot.
    req_take  = i_req_val & adv;    // also the cell enable.
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ret_val <= 1'b0;
    end else if (adv) begin
      ret_val <= i_req_val;  // fill, refill or drain.
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_take) begin
      ret_tag <= i_req.tag;  // lines up with the cell results.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // xi = 1 + u product cells.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fp_mod_addsub #(
    .SUB   (1'b1)
  ) sub_inst (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_en  (req_take),
    .i_a   (i_req.dat.c0),  // a.
    .i_b   (i_req.dat.c1),  // b.
    .o_res (res_c0)
  );

  fp_mod_addsub #(
    .SUB   (1'b0)
  ) add_inst (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_en  (req_take),
    .i_a   (i_req.dat.c0),
    .i_b   (i_req.dat.c1),
    .o_res (res_c1)
  );

  always_comb begin
    o_ret_val    = ret_val;
    o_ret.dat.c0 = res_c0;
    o_ret.dat.c1 = res_c1;
    o_ret.tag    = ret_tag;
  end

  // a stalled return must not change under the consumer.
  a_ret_hold : assert property (
    @(posedge i_clk) disable iff (i_rst)
    (o_ret_val && !i_ret_rdy) |=> (o_ret_val && $stable(o_ret))
  ) else $error("fe2_mul_by_nonresidue: return changed under stall.");

endmodule

/* design/fe6_mul_by_nonresidue.sv */
`timescale 1ns/10ps

module fe6_mul_by_nonresidue
  import fe6_mnr_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  // fp6 input, multiplied by v.
  input  fe6_beat_t i_fe6,
  input  logic      i_fe6_val,
  output logic      o_fe6_rdy,
  // fp6 result, (xi*c2, c0, c1).
  output fe6_beat_t o_fe6,
  output logic      o_fe6_val,
  input  logic      i_fe6_rdy,
  // c2 sent out for the xi product.
  output fe2_beat_t o_fe2_req,
  output logic      o_fe2_req_val,
  input  logic      i_fe2_req_rdy,
  // xi*c2 coming back.
  input  fe2_beat_t i_fe2_ret,
  input  logic      i_fe2_ret_val,
  output logic      o_fe2_ret_rdy
);

  logic [2:0] val;       // slot valid, one bit per output coefficient.
  fe6_beat_t  slot;      // output slots plus tag.
  fe2_beat_t  req;       // pending fp2 request.
  logic       req_val;   // request register full.
  logic       req_free;  // request register empty or draining.
  logic       fe6_take;  // input transfer this edge.
  logic       out_take;  // output transfer this edge.
  logic       ret_take;  // return transfer this edge.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    req_free      = ~req_val | i_fe2_req_rdy;
    o_fe6_rdy     = ~val[1] & ~val[2] & req_free;  // one item at a time.
    o_fe6_val     = &val;                          // all three slots in.
    out_take      = o_fe6_val & i_fe6_rdy;
    o_fe2_ret_rdy = ~val[0] | out_take;            // c0 slot free.
    fe6_take      = i_fe6_val & o_fe6_rdy;
    ret_take      = i_fe2_ret_val & o_fe2_ret_rdy;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // slot and request control.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val     <= 3'b000;
      req_val <= 1'b0;
    end else begin
      if (out_take) begin
        val <= 3'b000;  // item leaves, slots free.
      end
      if (fe6_take) begin
        val[2:1] <= 2'b11;  // c0 and c1 rotate in at once.
      end
      if (ret_take) begin
        val[0] <= 1'b1;  // xi*c2 landed.
      end
      if (req_free) begin
        req_val <= fe6_take;  // request valid from the input edge.
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // payload.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge i_clk) begin
    if (fe6_take) begin
      slot.dat.c1 <= i_fe6.dat.c0;  // c0 -> v coefficient.
      slot.dat.c2 <= i_fe6.dat.c1;  // c1 -> v^2 coefficient.
      req.dat     <= i_fe6.dat.c2;  // c2 goes out for xi.
      req.tag     <= i_fe6.tag;
    end
    if (ret_take) begin
      slot.dat.c0 <= i_fe2_ret.dat;
      slot.tag    <= i_fe2_ret.tag;  // tag rides back with the product.
    end
  end

  always_comb begin
    o_fe6         = slot;
    o_fe2_req     = req;
    o_fe2_req_val = req_val;
  end

  // once an item is in, no other input gets in until it leaves,
  // which keeps slot c1 from being overwritten.
  a_one_in_flight : assert property (
    @(posedge i_clk) disable iff (i_rst)
    fe6_take |=> (!fe6_take until_with out_take)
  ) else $error("fe6_mul_by_nonresidue: input taken while slot c1 full.");

endmodule

/* design/fe6_mnr_unit.sv */
`timescale 1ns/10ps

module fe6_mnr_unit
  import fe6_mnr_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  // fp6 in.
  input  fe6_beat_t i_fe6,
  input  logic      i_fe6_val,
  output logic      o_fe6_rdy,
  // fp6 out, v times the input.
  output fe6_beat_t o_fe6,
  output logic      o_fe6_val,
  input  logic      i_fe6_rdy
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // internal fp2 channel.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  fe2_beat_t fe2_req;      // c2 toward the xi block.
  logic      fe2_req_val;
  logic      fe2_req_rdy;
  fe2_beat_t fe2_ret;      // xi*c2 back.
  logic      fe2_ret_val;
  logic      fe2_ret_rdy;

  // rotation and slot assembly.
  fe6_mul_by_nonresidue fe6_mnr_inst (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_fe6         (i_fe6),
    .i_fe6_val     (i_fe6_val),
    .o_fe6_rdy     (o_fe6_rdy),
    .o_fe6         (o_fe6),
    .o_fe6_val     (o_fe6_val),
    .i_fe6_rdy     (i_fe6_rdy),
    .o_fe2_req     (fe2_req),
    .o_fe2_req_val (fe2_req_val),
    .i_fe2_req_rdy (fe2_req_rdy),
    .i_fe2_ret     (fe2_ret),
    .i_fe2_ret_val (fe2_ret_val),
    .o_fe2_ret_rdy (fe2_ret_rdy)
  );

  // xi = 1 + u product, one cycle.
  fe2_mul_by_nonresidue fe2_mnr_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req     (fe2_req),
    .i_req_val (fe2_req_val),
    .o_req_rdy (fe2_req_rdy),
    .o_ret     (fe2_ret),
    .o_ret_val (fe2_ret_val),
    .i_ret_rdy (fe2_ret_rdy)
  );

endmodule

/* verif/tb_fe6_mnr_model.svh */
`ifndef TB_FE6_MNR_MODEL_SVH
`define TB_FE6_MNR_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model from the field rules.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic fe_t model_add(input fe_t a, input fe_t b);
  logic [`FE_BITS:0] s;  // 382-bit sum.
  s = {1'b0, a} + {1'b0, b};
  if (s >= {1'b0, `FE_MODULUS}) begin
    s = s - {1'b0, `FE_MODULUS};  // back under p.
  end
  return s[`FE_BITS-1:0];
endfunction

function automatic fe_t model_sub(input fe_t a, input fe_t b);
  logic [`FE_BITS:0] d;  // 382-bit difference.
  if (a >= b) begin
    d = {1'b0, a} - {1'b0, b};
  end else begin
    d = {1'b0, a} + {1'b0, `FE_MODULUS} - {1'b0, b};  // wrap through p.
  end
  return d[`FE_BITS-1:0];
endfunction

// (a + b*u)(1 + u) = (a - b) + (a + b)*u.
function automatic fe2_t model_mul_xi(input fe2_t x);
  fe2_t r;
  r.c0 = model_sub(x.c0, x.c1);
  r.c1 = model_add(x.c0, x.c1);
  return r;
endfunction

// v*(c0, c1, c2) = (xi*c2, c0, c1).
function automatic fe6_t model_mul_v(input fe6_t x);
  fe6_t r;
  r.c0 = model_mul_xi(x.c2);
  r.c1 = x.c0;  // rotates up one slot.
  r.c2 = x.c1;
  return r;
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare tasks per result kind.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic compare_fe6(input string name, input fe6_t exp, input fe6_t act);
  check_count++;
  if (act !== exp) begin
    err_count++;
    $display("Mismatch %s %s: expected %h actual %h", test_name, name, exp, act);
  end
endtask

task automatic compare_tag(input string name, input tag_t exp, input tag_t act);
  check_count++;
  if (act !== exp) begin
    err_count++;
    $display("Mismatch %s %s tag: expected %h actual %h", test_name, name, exp, act);
  end
endtask

task automatic compare_int(input string name, input int exp, input int act);
  check_count++;
  if (act != exp) begin
    err_count++;
    $display("Mismatch %s %s: expected %0d actual %0d", test_name, name, exp, act);
  end
endtask

`endif

/* verif/tb_fe6_mnr_unit.sv */
`timescale 1ns/10ps
`include "fe6_mnr_settings.svh"

module tb_fe6_mnr_unit
  import fe6_mnr_pkg::*;
();

  localparam int  RESET_CYCLES = 16;
  localparam int  N_RANDOM     = 20;
  localparam int  N_ITEMS      = 8 + N_RANDOM;  // small, edge, stall and random items.
  localparam int  WORST_LAT    = 3;             // unstalled input to output.
  localparam int  STALL_ALLOW  = 16;            // per item allowance for output back-pressure.
  localparam int  WATCH_CYCLES = RESET_CYCLES + N_ITEMS * (WORST_LAT + STALL_ALLOW) + 100;
  localparam fe_t P_M1         = `FE_MODULUS - 381'd1;

  logic      i_clk;
  logic      i_rst;
  fe6_beat_t i_fe6;
  logic      i_fe6_val;
  logic      o_fe6_rdy;
  fe6_beat_t o_fe6;
  logic      o_fe6_val;
  logic      i_fe6_rdy;

  integer    seed = 32'hf169cffd;
  int        check_count = 0;
  int        err_count = 0;
  int        test_count = 0;
  int        test_fails = 0;
  int        test_err0;    // error count when the current test began.
  string     test_name;
  fe6_beat_t exp_q[$];     // expected outputs in arrival order.

  `include "tb_fe6_mnr_model.svh"

  fe6_mnr_unit fe6_mnr_unit_inst (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_fe6     (i_fe6),
    .i_fe6_val (i_fe6_val),
    .o_fe6_rdy (o_fe6_rdy),
    .o_fe6     (o_fe6),
    .o_fe6_val (o_fe6_val),
    .i_fe6_rdy (i_fe6_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;  // 100 ns period.
  end

  initial begin
    repeat (WATCH_CYCLES) @(posedge i_clk);
    $display("watchdog: run did not finish within %0d cycles", WATCH_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic fe6_beat_t make_beat(input fe_t a0, b0, a1, b1, a2, b2, input tag_t tag);
    fe6_beat_t b;
    b.dat.c0.c0 = a0;
    b.dat.c0.c1 = b0;
    b.dat.c1.c0 = a1;
    b.dat.c1.c1 = b1;
    b.dat.c2.c0 = a2;
    b.dat.c2.c1 = b2;
    b.tag       = tag;
    return b;
  endfunction

  function automatic fe6_beat_t expected_beat(input fe6_beat_t b);
    fe6_beat_t e;
    e.dat = model_mul_v(b.dat);
    e.tag = b.tag;  // tag follows its item.
    return e;
  endfunction

  // 384 random bits folded once into [0, p) since 2^381 < 2p.
  function automatic fe_t rand_fe();
    logic [383:0] w;
    integer       r;
    w = '0;
    for (int k = 0; k < 12; k++) begin
      r = $random(seed);
      w = {w[351:0], r};
    end
    if (w[380:0] >= `FE_MODULUS) begin
      w[380:0] = w[380:0] - `FE_MODULUS;
    end
    return w[380:0];
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = err_count;
    test_count++;
  endtask

  task automatic end_test();
    if (err_count == test_err0) begin
      $display("%s: passed", test_name);
    end else begin
      test_fails++;
      $display("%s: failed with %0d errors", test_name, err_count - test_err0);
    end
  endtask

  task automatic flag_error(input string msg);
    err_count++;
    $display("%s", msg);
  endtask

  // returns on the rising edge where the beat transfers; valid stays high.
  task automatic offer_input(input fe6_beat_t beat);
    @(negedge i_clk);
    i_fe6     = beat;
    i_fe6_val = 1'b1;
    while (!o_fe6_rdy) @(negedge i_clk);
    @(posedge i_clk);
  endtask

  // lat counts rising edges from the input transfer to the output transfer.
  task automatic await_output(input string name, input fe6_beat_t exp, output int lat);
    @(negedge i_clk);
    i_fe6_val = 1'b0;
    lat = 1;
    while (!o_fe6_val) begin
      @(negedge i_clk);
      lat++;
    end
    compare_fe6(name, exp.dat, o_fe6.dat);
    compare_tag(name, exp.tag, o_fe6.tag);
  endtask

  task automatic run_single(input string name, input fe6_beat_t beat);
    int lat;
    offer_input(beat);
    await_output(name, expected_beat(beat), lat);
    compare_int({name, " latency"}, WORST_LAT, lat);
    @(posedge i_clk);  // output taken while i_fe6_rdy is high.
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_reset();
    start_test("reset_state");
    @(negedge i_clk);
    if (o_fe6_val !== 1'b0) flag_error("reset_state: o_fe6_val is not low after reset");
    if (o_fe6_rdy !== 1'b1) flag_error("reset_state: o_fe6_rdy is not high after reset");
    end_test();
  endtask

  task automatic test_small();
    start_test("small_values");
    run_single("small 1", make_beat(1, 2, 3, 4, 5, 6, 8'h11));
    run_single("small 2", make_beat(9, 8, 7, 6, 100, 7, 8'h22));
    run_single("small 3", make_beat(0, 0, 0, 0, 0, 0, 8'h33));
    end_test();
  endtask

  task automatic test_edges();
    start_test("reduction_edges");
    run_single("edge a<b", make_beat(1, 2, 3, 4, 1, 5, 8'h01));          // sub wraps.
    run_single("edge a+b>=p", make_beat(5, 6, 7, 8, P_M1, 2, 8'h02));    // add folds.
    run_single("edge a=b=p-1", make_beat(P_M1, P_M1, P_M1, P_M1, P_M1, P_M1, 8'h03));
    end_test();
  endtask

  task automatic test_backpressure();
    fe6_beat_t a;
    fe6_beat_t b;
    fe6_beat_t held;
    int        lat;
    start_test("backpressure");
    a = make_beat(11, 22, 33, 44, P_M1, 3, 8'ha5);
    b = make_beat(55, 66, 77, 88, 4, P_M1, 8'h5a);
    @(negedge i_clk);
    i_fe6_rdy = 1'b0;
    offer_input(a);
    @(negedge i_clk);
    i_fe6 = b;  // second item waits at the input.
    while (!o_fe6_val) @(negedge i_clk);
    held = o_fe6;
    compare_fe6("backpressure first", expected_beat(a).dat, held.dat);
    compare_tag("backpressure first", a.tag, held.tag);
    repeat (6) begin
      @(negedge i_clk);
      compare_fe6("backpressure hold", held.dat, o_fe6.dat);
      compare_tag("backpressure hold", held.tag, o_fe6.tag);
      if (!o_fe6_val) flag_error("backpressure: output valid dropped during stall");
      if (o_fe6_rdy) flag_error("backpressure: input ready while an item was in flight");
    end
    i_fe6_rdy = 1'b1;
    @(posedge i_clk);  // first item leaves.
    offer_input(b);
    await_output("backpressure second", expected_beat(b), lat);
    compare_int("backpressure second latency", WORST_LAT, lat);
    @(posedge i_clk);
    end_test();
  endtask

  task automatic test_random_stream();
    fe6_beat_t items[N_RANDOM];
    fe6_beat_t exp;
    int        got;
    start_test("random_stream");
    for (int i = 0; i < N_RANDOM; i++) begin
      items[i].dat.c0.c0 = rand_fe();
      items[i].dat.c0.c1 = rand_fe();
      items[i].dat.c1.c0 = rand_fe();
      items[i].dat.c1.c1 = rand_fe();
      items[i].dat.c2.c0 = rand_fe();
      items[i].dat.c2.c1 = rand_fe();
      items[i].tag       = tag_t'($random(seed));
    end
    exp_q.delete();
    got = 0;
    fork
      begin
        for (int i = 0; i < N_RANDOM; i++) begin
          offer_input(items[i]);
          exp_q.push_back(expected_beat(items[i]));  // queued on the transfer edge.
        end
        @(negedge i_clk);
        i_fe6_val = 1'b0;
      end
      begin
        while (got < N_RANDOM) begin
          @(negedge i_clk);
          i_fe6_rdy = ($random(seed) % 2) != 0;  // random output stall.
          if (o_fe6_val && i_fe6_rdy) begin
            if (exp_q.size() == 0) begin
              flag_error("random_stream: output appeared with no item outstanding");
            end else begin
              exp = exp_q.pop_front();
              compare_fe6("random_stream", exp.dat, o_fe6.dat);
              compare_tag("random_stream", exp.tag, o_fe6.tag);
            end
            got++;
          end
        end
      end
    join
    @(posedge i_clk);  // last output taken.
    end_test();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    i_rst     = 1'b1;
    i_fe6     = '0;
    i_fe6_val = 1'b0;
    i_fe6_rdy = 1'b1;
    repeat (RESET_CYCLES) @(negedge i_clk);
    i_rst = 1'b0;
    test_reset();
    test_small();
    test_edges();
    test_backpressure();
    test_random_stream();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_count, test_fails, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* fe6_mnr_unit.f */
+incdir+design
+incdir+verif
design/fe6_mnr_pkg.sv
design/fp_mod_addsub.sv
design/fe2_mul_by_nonresidue.sv
design/fe6_mul_by_nonresidue.sv
design/fe6_mnr_unit.sv
verif/tb_fe6_mnr_unit.sv
